/* Makefile */
# Verilator build and run of the MSU audio stream testbench

SIM := obj_dir/Vmsu_audio_tb

all: run

# Rebuilt only when the file list or a listed source changes
$(SIM): all.f $(shell cat all.f)
	verilator --binary --timing --assert -Wno-fatal --top-module msu_audio_tb \
		-Mdir obj_dir -f all.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* all.f */
common/msu_pkg.sv
msu_stream/msu_word_intake.sv
msu_stream/msu_sample_fifo.sv
msu_stream/msu_sample_player.sv
hdl/msu_audio_top.sv
bench/msu_audio_asserts.sv
bench/msu_audio_tb.sv

/* bench/msu_audio_asserts.sv */
/*
 * MSU audio stream assertions
 * FIFO write and read rules and player read rules, bound into the top level
 */

`timescale 1ns/100ps
`default_nettype none

module msu_audio_asserts #(
	parameter int FIFO_ADDR_BITS = 4
) (
	input wire logic                    clk_sys,
	input wire logic                    reset,
	input wire logic                    trig_play,
	input wire logic                    fifo_wr,
	input wire logic                    fifo_rd,
	input wire logic                    play,
	input wire logic [FIFO_ADDR_BITS:0] buffer_level
);

	localparam int DEPTH = 1 << FIFO_ADDR_BITS;

	int fail_count = 0;

	// Intake never writes into a buffer that already holds DEPTH words
	no_write_when_full: assert property (@(posedge clk_sys) disable iff (reset)
		fifo_wr |-> (buffer_level < DEPTH))
		else begin
			$error("FIFO written while holding %0d words", buffer_level);
			fail_count++;
		end

	// A pop takes one stored word, a read on an empty buffer wraps the level
	no_read_when_empty: assert property (@(posedge clk_sys) disable iff (reset)
		fifo_rd |=> int'(buffer_level) ==
			int'($past(buffer_level)) + int'($past(fifo_wr)) - 1)
		else begin
			$error("FIFO read while empty");
			fail_count++;
		end

	level_in_range: assert property (@(posedge clk_sys) disable iff (reset)
		buffer_level <= DEPTH)
		else begin
			$error("FIFO level %0d above depth", buffer_level);
			fail_count++;
		end

	// With play low only a flush may lower the level
	read_only_on_play: assert property (@(posedge clk_sys) disable iff (reset)
		!play && !trig_play |=> buffer_level >= $past(buffer_level))
		else begin
			$error("FIFO read while play is low");
			fail_count++;
		end

endmodule

bind msu_audio_top msu_audio_asserts #(
	.FIFO_ADDR_BITS (FIFO_ADDR_BITS)
) u_asserts (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.trig_play    (trig_play),
	.fifo_wr      (fifo_wr),
	.fifo_rd      (fifo_rd),
	.play         (play),
	.buffer_level (buffer_level)
);

`default_nettype wire

/* bench/msu_audio_tb.sv */
/*
 * MSU audio stream testbench
 * Table-driven tests of header skip, L/R pairing, volume mix, play low,
 * flush and overflow, checked against a model of the stream rules
 */

`timescale 1ns/100ps
`default_nettype none

module msu_audio_tb;

	import msu_pkg::*;

	localparam int SAMPLE_DIV     = 8;
	localparam int FIFO_ADDR_BITS = 4;
	localparam int DEPTH          = 1 << FIFO_ADDR_BITS;
	localparam int NUM_TESTS      = 7;

	typedef struct {
		string name;
		int    sectors;
		int    words;
		bit    first_zero;
		bit    play;
		int    vol;
		int    main_l_v;
		int    main_r_v;
		bit    trig;
	} test_t;

	logic                    clk_sys;
	logic                    reset;
	logic                    sector_start;
	logic                    sector_zero;
	logic                    word_wr;
	logic [15:0]             word_data;
	logic                    trig_play;
	logic                    play;
	logic [7:0]              volume;
	sample_t                 main_l;
	sample_t                 main_r;
	sample_t                 audio_l;
	sample_t                 audio_r;
	logic [FIFO_ADDR_BITS:0] buffer_level;

	test_t       tests [NUM_TESTS];
	logic [31:0] rng_state;
	logic [16:0] model_q [$];
	bit          model_right;
	int          hold_l;
	int          check_count;
	int          error_count;

	msu_audio_top #(
		.SAMPLE_DIV     (SAMPLE_DIV),
		.FIFO_ADDR_BITS (FIFO_ADDR_BITS)
	) UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sector_start (sector_start),
		.sector_zero  (sector_zero),
		.word_wr      (word_wr),
		.word_data    (word_data),
		.trig_play    (trig_play),
		.play         (play),
		.volume       (volume),
		.main_l       (main_l),
		.main_r       (main_r),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.buffer_level (buffer_level)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ====================================================================
	// Model and helpers
	// ====================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Volume scaling followed by the halving add with main audio
	function automatic int mix_expected(input int main_v, input int samp, input int vol);
		int scaled;
		scaled = (samp * vol) >>> 8;
		return (main_v + scaled) >>> 1;
	endfunction

	task automatic check_value(input string test_name, input string what,
			input int expected, input int actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("Error in %s, %s: expected %0d, actual %0d",
				test_name, what, expected, actual);
		end
	endtask

	// Header words of sector 0 are skipped, a full buffer drops the word
	task automatic model_word(input bit zero, input int idx, input logic [15:0] w);
		if (zero && idx < HEADER_WORDS)
			return;
		if (model_q.size() < DEPTH)
			model_q.push_back({zero && (idx == HEADER_WORDS), w});
	endtask

	task automatic write_sector(input bit zero, input int n);
		int i;
		logic [15:0] w;
		@(posedge clk_sys);
		sector_start <= 1'b1;
		sector_zero  <= zero;
		for (i = 0; i < n; i++) begin
			@(posedge clk_sys);
			sector_start <= 1'b0;
			rng_state = xorshift32(rng_state);
			w = rng_state[15:0];
			word_wr   <= 1'b1;
			word_data <= w;
			model_word(zero, i, w);
		end
		@(posedge clk_sys);
		sector_start <= 1'b0;
		word_wr      <= 1'b0;
		sector_zero  <= 1'b0;
	endtask

	task automatic flush_track(input string test_name);
		@(posedge clk_sys);
		trig_play <= 1'b1;
		@(posedge clk_sys);
		trig_play <= 1'b0;
		model_q.delete();
		model_right = 1'b0;
		@(negedge clk_sys);
		check_value(test_name, "level after flush", 0, buffer_level);
	endtask

	// Each drop of the level is one pop, a right pop updates the outputs
	task automatic play_back(input test_t tc);
		int n;
		int pops;
		int prev;
		int lvl;
		int smp;
		logic [16:0] wd;
		n = model_q.size();
		@(posedge clk_sys);
		play <= 1'b1;
		@(negedge clk_sys);
		prev = buffer_level;
		pops = 0;
		while (pops < n) begin
			@(negedge clk_sys);
			lvl = buffer_level;
			if (lvl < prev) begin
				wd = model_q.pop_front();
				smp = $signed(wd[15:0]);
				pops++;
				if (!model_right || wd[16]) begin
					hold_l = smp;
					model_right = 1'b1;
				end else begin
					check_value(tc.name, "audio_l",
						mix_expected(tc.main_l_v, hold_l, tc.vol), audio_l);
					check_value(tc.name, "audio_r",
						mix_expected(tc.main_r_v, smp, tc.vol), audio_r);
					model_right = 1'b0;
				end
			end
			prev = lvl;
		end
		@(posedge clk_sys);
		play <= 1'b0;
		@(negedge clk_sys);
		check_value(tc.name, "level after playback", 0, buffer_level);
	endtask

	task automatic hold_check(input test_t tc);
		int lvl;
		int i;
		lvl = buffer_level;
		for (i = 0; i < 4 * SAMPLE_DIV; i++) begin
			@(negedge clk_sys);
			check_value(tc.name, "level with play low", lvl, buffer_level);
		end
		check_value(tc.name, "audio_l with play low", tc.main_l_v >>> 1, audio_l);
		check_value(tc.name, "audio_r with play low", tc.main_r_v >>> 1, audio_r);
	endtask

	task automatic run_test(input test_t tc);
		int s;
		@(posedge clk_sys);
		play   <= 1'b0;
		volume <= tc.vol[7:0];
		main_l <= tc.main_l_v[15:0];
		main_r <= tc.main_r_v[15:0];
		if (tc.trig)
			flush_track(tc.name);
		for (s = 0; s < tc.sectors; s++)
			write_sector(tc.first_zero && (s == 0), tc.words);
		// Intake register plus FIFO write
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value(tc.name, "level after fill", model_q.size(), buffer_level);
		if (tc.play)
			play_back(tc);
		else
			hold_check(tc);
	endtask

	// ====================================================================
	// Test table and sequence
	// ====================================================================

	initial begin
		int t;
		reset        = 1'b1;
		sector_start = 1'b0;
		sector_zero  = 1'b0;
		word_wr      = 1'b0;
		word_data    = '0;
		trig_play    = 1'b0;
		play         = 1'b0;
		volume       = '0;
		main_l       = '0;
		main_r       = '0;
		rng_state    = 32'hb4d;
		model_right  = 1'b0;
		hold_l       = 0;
		check_count  = 0;
		error_count  = 0;

		// name, sectors, words, sector 0, play, volume, main L/R, trig_play
		tests[0] = '{"header_skip", 2, 8, 1'b1, 1'b1, 255, 0, 0, 1'b1};
		tests[1] = '{"mid_track", 2, 6, 1'b0, 1'b1, 128, 1000, -1000, 1'b0};
		tests[2] = '{"volume_zero", 1, 9, 1'b0, 1'b1, 0, -300, 700, 1'b0};
		// Sector 0 behind a held left word restarts the pairing on the left
		tests[3] = '{"negative_mix", 1, 12, 1'b1, 1'b1, 255, -20000, 15000, 1'b0};
		tests[4] = '{"play_low", 1, 8, 1'b0, 1'b0, 200, 1234, -4321, 1'b0};
		tests[5] = '{"flush", 1, 8, 1'b0, 1'b1, 64, -5000, 5000, 1'b1};
		tests[6] = '{"overflow", 1, 20, 1'b0, 1'b1, 192, 300, -300, 1'b0};

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		for (t = 0; t < NUM_TESTS; t++)
			run_test(tests[t]);
		@(posedge clk_sys);
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			check_count, error_count, UUT.u_asserts.fail_count);
		if (error_count == 0 && UUT.u_asserts.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Twice the table's word count at one word per sample tick
	initial begin : watchdog
		int total;
		int i;
		#1;
		total = 0;
		for (i = 0; i < NUM_TESTS; i++)
			total += tests[i].sectors * tests[i].words;
		#(2 * total * SAMPLE_DIV * 10);
		$display("Timeout: the tests did not finish within %0d ns",
			2 * total * SAMPLE_DIV * 10);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* common/msu_pkg.sv */
/*
 * MSU audio stream package
 * Sample and FIFO word types, the player phase and the stream constants
 * shared by the intake, buffer and player stages
 */

`default_nettype none

package msu_pkg;

	// =====================================================================
	// Types
	// =====================================================================

	// Same width and format as the console audio
	typedef logic signed [15:0] sample_t;

	// One buffered word, first_left marks the first audio word of a track
	typedef struct packed {
		logic    first_left;
		sample_t sample;
	} fifo_word_t;

	// Which half of a stereo pair the next word belongs to
	typedef enum logic {
		phase_left,
		phase_right
	} play_phase_t;

	// =====================================================================
	// Constants
	// =====================================================================

	// "MSU1" tag plus the 32-bit loop point at the start of sector 0
	localparam int HEADER_WORDS = 4;

	// 512-byte sector, 256 words
	localparam int SECTOR_WORD_BITS = 8;

	// Volume is 0..255, so the product is scaled back by 8 bits
	localparam int VOL_SHIFT = 8;

	// Clocks per sample tick
	localparam int DEFAULT_SAMPLE_DIV = 567;
	localparam int DEFAULT_FIFO_ADDR_BITS = 10;

endpackage

`default_nettype wire

/* hdl/msu_audio_top.sv */
/*
 * MSU audio streaming top level
 * Sector words go through the intake and the sample FIFO to the player,
 * which mixes the track into the console audio
 */

`timescale 1ns/100ps
`default_nettype none

module msu_audio_top #(
	parameter int SAMPLE_DIV     = msu_pkg::DEFAULT_SAMPLE_DIV,
	parameter int FIFO_ADDR_BITS = msu_pkg::DEFAULT_FIFO_ADDR_BITS
) (
	input  wire logic                    clk_sys,
	input  wire logic                    reset,
	// Sector stream
	input  wire logic                    sector_start,
	input  wire logic                    sector_zero,
	input  wire logic                    word_wr,
	input  wire logic [15:0]             word_data,
	// Control
	input  wire logic                    trig_play,
	input  wire logic                    play,
	input  wire logic [7:0]              volume,
	// Console audio
	input  wire msu_pkg::sample_t        main_l,
	input  wire msu_pkg::sample_t        main_r,
	output      msu_pkg::sample_t        audio_l,
	output      msu_pkg::sample_t        audio_r,
	output      logic [FIFO_ADDR_BITS:0] buffer_level
);

	import msu_pkg::*;

	logic       fifo_wr;
	fifo_word_t fifo_data;
	logic       fifo_full;
	logic       fifo_empty;
	logic       fifo_rd;
	fifo_word_t fifo_rd_data;

	msu_word_intake u_intake (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sector_start (sector_start),
		.sector_zero  (sector_zero),
		.word_wr      (word_wr),
		.word_data    (word_data),
		.full         (fifo_full),
		.fifo_wr      (fifo_wr),
		.fifo_data    (fifo_data)
	);

	// trig_play drops everything buffered for the previous track
	msu_sample_fifo #(
		.FIFO_ADDR_BITS (FIFO_ADDR_BITS)
	) u_fifo (
		.clk_sys (clk_sys),
		.reset   (reset),
		.flush   (trig_play),
		.wr      (fifo_wr),
		.wr_data (fifo_data),
		.rd      (fifo_rd),
		.rd_data (fifo_rd_data),
		.full    (fifo_full),
		.empty   (fifo_empty),
		.level   (buffer_level)
	);

	msu_sample_player #(
		.SAMPLE_DIV (SAMPLE_DIV)
	) u_player (
		.clk_sys (clk_sys),
		.reset   (reset),
		.flush   (trig_play),
		.play    (play),
		.volume  (volume),
		.main_l  (main_l),
		.main_r  (main_r),
		.empty   (fifo_empty),
		.rd_data (fifo_rd_data),
		.rd      (fifo_rd),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

`default_nettype wire

/* msu_stream/msu_sample_fifo.sv */
/*
 * MSU sample FIFO
 * Single-clock show-ahead circular buffer of tagged words with a fill
 * level and a one-cycle flush
 */

`timescale 1ns/100ps
`default_nettype none

module msu_sample_fifo #(
	parameter int FIFO_ADDR_BITS = msu_pkg::DEFAULT_FIFO_ADDR_BITS
) (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire logic                  flush,
	input  wire logic                  wr,
	input  wire msu_pkg::fifo_word_t   wr_data,
	input  wire logic                  rd,
	output      msu_pkg::fifo_word_t   rd_data,
	output      logic                  full,
	output      logic                  empty,
	output      logic [FIFO_ADDR_BITS:0] level
);

	import msu_pkg::*;

	localparam logic [FIFO_ADDR_BITS:0] DEPTH = 1 << FIFO_ADDR_BITS;

	fifo_word_t mem [DEPTH];

	logic [FIFO_ADDR_BITS-1:0] wr_ptr;
	logic [FIFO_ADDR_BITS-1:0] rd_ptr;
	logic [FIFO_ADDR_BITS:0]   count;
	logic [FIFO_ADDR_BITS:0]   count_next;

	assign count_next = count + {{FIFO_ADDR_BITS{1'b0}}, wr} - {{FIFO_ADDR_BITS{1'b0}}, rd};

	// The intake registers its word before writing, so full looks one
	// write ahead: high when the slot for a newly accepted word is taken
	assign full  = (count_next >= DEPTH);
	assign empty = (count == '0);
	assign level = count;

	// Head word is visible without a read strobe
	assign rd_data = mem[rd_ptr];

	// =====================================================================
	// Pointers and count
	// =====================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
		end
	end

	// =====================================================================
	// Storage
	// =====================================================================

	always_ff @(posedge clk_sys) begin
		if (wr && !flush)
			mem[wr_ptr] <= wr_data;
	end

endmodule

`default_nettype wire

/* msu_stream/msu_sample_player.sv */
/*
 * MSU sample player
 * Pulls one word per sample tick, pairs the words as left and right,
 * scales the pair by the volume and mixes it into the console audio
 */

`timescale 1ns/100ps
`default_nettype none

module msu_sample_player #(
	parameter int SAMPLE_DIV = msu_pkg::DEFAULT_SAMPLE_DIV
) (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire logic                flush,
	input  wire logic                play,
	input  wire logic [7:0]          volume,
	input  wire msu_pkg::sample_t    main_l,
	input  wire msu_pkg::sample_t    main_r,
	input  wire logic                empty,
	input  wire msu_pkg::fifo_word_t rd_data,
	output      logic                rd,
	output      msu_pkg::sample_t    audio_l,
	output      msu_pkg::sample_t    audio_r
);

	import msu_pkg::*;

	localparam int DIV_BITS = $clog2(SAMPLE_DIV);

	logic [DIV_BITS-1:0] div_cnt;
	logic                tick;
	logic                left_word;
	play_phase_t         phase;
	sample_t             hold_l;
	sample_t             samp_l;
	sample_t             samp_r;

	// Volume scaling and halving add for one channel
	function automatic sample_t mix_channel(
		input sample_t    main_s,
		input sample_t    msu_s,
		input logic [7:0] vol,
		input logic       en
	);
		logic signed [24:0] prod;
		sample_t            scaled;
		logic signed [16:0] sum;
		begin
			prod   = msu_s * $signed({1'b0, vol});
			scaled = en ? sample_t'(prod >>> VOL_SHIFT) : '0;
			sum    = $signed({main_s[15], main_s}) + $signed({scaled[15], scaled});
			mix_channel = sum[16:1];
		end
	endfunction

	// =====================================================================
	// Sample clock and FIFO read
	// =====================================================================

	assign tick = (div_cnt == DIV_BITS'(SAMPLE_DIV - 1));
	assign rd   = tick && play && !empty && !flush;

	// First audio word of a track restarts the pairing on the left
	assign left_word = (phase == phase_left) || rd_data.first_left;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt <= '0;
			phase   <= phase_left;
			samp_l  <= '0;
			samp_r  <= '0;
		end else if (flush) begin
			div_cnt <= '0;
			phase   <= phase_left;
			samp_l  <= '0;
			samp_r  <= '0;
		end else begin
			if (tick)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;

			// Phase moves only on a real read, an underrun keeps L/R in place
			if (rd) begin
				if (left_word) begin
					phase <= phase_right;
				end else begin
					samp_l <= hold_l;
					samp_r <= rd_data.sample;
					phase  <= phase_left;
				end
			end
		end
	end

	// Left word waits here until its right partner arrives
	always_ff @(posedge clk_sys) begin
		if (rd && left_word)
			hold_l <= rd_data.sample;
	end

	// =====================================================================
	// Output mix
	// =====================================================================

	assign audio_l = mix_channel(main_l, samp_l, volume, play);
	assign audio_r = mix_channel(main_r, samp_r, volume, play);

endmodule

`default_nettype wire

/* msu_stream/msu_word_intake.sv */
/*
 * MSU word intake
 * Counts the words of each sector, skips the track header in sector 0,
 * drops words while the buffer is full and tags the first audio word
 */

`timescale 1ns/100ps
`default_nettype none

module msu_word_intake (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire logic                sector_start,
	input  wire logic                sector_zero,
	input  wire logic                word_wr,
	input  wire logic [15:0]         word_data,
	input  wire logic                full,
	output      logic                fifo_wr,
	output      msu_pkg::fifo_word_t fifo_data
);

	import msu_pkg::*;

	logic [SECTOR_WORD_BITS-1:0] word_cnt;
	logic [SECTOR_WORD_BITS-1:0] word_idx;
	logic                        header_word;
	logic                        first_word;
	logic                        accept;

	// A word arriving together with sector_start is word 0
	assign word_idx = sector_start ? '0 : word_cnt;

	assign header_word = sector_zero && (word_idx < HEADER_WORDS);
	assign first_word  = sector_zero && (word_idx == HEADER_WORDS);

	// Full buffer is the only back-pressure, the word is simply lost
	assign accept = word_wr && !header_word && !full;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			word_cnt <= '0;
			fifo_wr  <= 1'b0;
		end else begin
			if (word_wr)
				word_cnt <= word_idx + 1'b1;
			else if (sector_start)
				word_cnt <= '0;
			fifo_wr <= accept;
		end
	end

	// Word register, qualified by fifo_wr
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			fifo_data.first_left <= first_word;
			fifo_data.sample     <= word_data;
		end
	end

endmodule

`default_nettype wire
